//--- Makefile
TOP := tb_rv_core

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard source/*.sv source/*.svh testbench/*.sv)
	verilator --binary --timing --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --top-module rv_core +incdir+source \
		source/rv_pipe_pkg.sv source/stage_reg.sv source/reg_file.sv \
		source/decode_stage.sv source/forward_unit.sv source/execute_stage.sv \
		source/rv_core.sv

clean:
	rm -rf obj_dir sim.log

//--- compile.f
+incdir+source
source/rv_pipe_pkg.sv
source/stage_reg.sv
source/reg_file.sv
source/decode_stage.sv
source/forward_unit.sv
source/execute_stage.sv
source/rv_core.sv
testbench/tb_clock.sv
testbench/tb_rv_core.sv

//--- source/decode_stage.sv
`include "rv_settings.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  rv_pipe_pkg::word_t     instr_i,
    input  logic                   wb_we_i,
    input  rv_pipe_pkg::reg_addr_t wb_rd_i,
    input  rv_pipe_pkg::word_t     wb_data_i,
    output logic                   valid_o,
    output rv_pipe_pkg::id_ex_t    ex_o
);
    import rv_pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      i_imm;
    word_t      u_imm;
    word_t      rs1_data;
    word_t      rs2_data;
    ctrl_t      ctrl;
    logic       legal;

    // funct3 to alu op, alt picks SUB / SRA
    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD_SUB: alu_decode = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     alu_decode = ALU_SLL;
            `F3_SLT:     alu_decode = ALU_SLT;
            `F3_SLTU:    alu_decode = ALU_SLTU;
            `F3_XOR:     alu_decode = ALU_XOR;
            `F3_SRL_SRA: alu_decode = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      alu_decode = ALU_OR;
            default:     alu_decode = ALU_AND;
        endcase
    endfunction

    // instruction fields
    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    // only I and U immediates remain
    assign i_imm = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign u_imm = {instr_i[31:12], 12'b0};

    always_comb begin
        ctrl.alu_op  = ALU_ADD;
        ctrl.use_imm = 1'b0;
        legal        = 1'b0;
        case (opcode)
            `OPC_OP: begin
                // funct7 alt only valid on ADD/SUB and SRL/SRA
                legal = (funct7 == `F7_BASE) ||
                        ((funct7 == `F7_ALT) &&
                         ((funct3 == `F3_ADD_SUB) || (funct3 == `F3_SRL_SRA)));
                ctrl.alu_op = alu_decode(funct3, funct7 == `F7_ALT);
            end
            `OPC_OP_IMM: begin
                ctrl.use_imm = 1'b1;
                if (funct3 == `F3_SLL) begin
                    legal = (funct7 == `F7_BASE);
                end else if (funct3 == `F3_SRL_SRA) begin
                    legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                end else begin
                    legal = 1'b1;
                end
                // ADDI has no subtract form, alt only for SRAI
                ctrl.alu_op = alu_decode(funct3,
                    (funct3 == `F3_SRL_SRA) && (funct7 == `F7_ALT));
            end
            `OPC_LUI: begin
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
                legal        = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        // x0 destination or illegal encoding writes nothing
        ctrl.reg_write = legal && (rd != '0);
    end

    reg_file reg_file_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .we_i       (wb_we_i),
        .wr_addr_i  (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // illegal instructions leave as bubbles
    assign valid_o = valid_i && legal;

    always_comb begin
        ex_o.ctrl     = ctrl;
        ex_o.rs1      = rs1;
        ex_o.rs2      = rs2;
        ex_o.rd       = rd;
        ex_o.rs1_data = rs1_data;
        ex_o.rs2_data = rs2_data;
        ex_o.imm      = (opcode == `OPC_LUI) ? u_imm : i_imm;
    end

endmodule

//--- source/execute_stage.sv
`include "rv_settings.svh"

module execute_stage (
    input  logic                   valid_i,
    input  rv_pipe_pkg::id_ex_t    ex_i,
    input  rv_pipe_pkg::word_t     mem_result_i,
    input  rv_pipe_pkg::word_t     wb_result_i,
    input  rv_pipe_pkg::reg_addr_t mem_rd_i,
    input  rv_pipe_pkg::reg_addr_t wb_rd_i,
    input  logic                   mem_we_i,
    input  logic                   wb_we_i,
    output logic                   valid_o,
    output rv_pipe_pkg::ex_mem_t   mem_o
);
    import rv_pipe_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    fwd_sel_t           fwd_a;
    fwd_sel_t           fwd_b;
    word_t              op_a;
    word_t              rs2_val;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    word_t              alu_result;

    forward_unit forward_unit_inst (
        .mem_we_i (mem_we_i),
        .wb_we_i  (wb_we_i),
        .ex_rs1_i (ex_i.rs1),
        .ex_rs2_i (ex_i.rs2),
        .mem_rd_i (mem_rd_i),
        .wb_rd_i  (wb_rd_i),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b)
    );

    // forwarding muxes
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem_result_i;
            FWD_WB:  op_a = wb_result_i;
            default: op_a = ex_i.rs1_data;
        endcase
        case (fwd_b)
            FWD_MEM: rs2_val = mem_result_i;
            FWD_WB:  rs2_val = wb_result_i;
            default: rs2_val = ex_i.rs2_data;
        endcase
    end

    // operand b, register or immediate
    assign op_b  = ex_i.ctrl.use_imm ? ex_i.imm : rs2_val;
    // shifts use low five bits only
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (ex_i.ctrl.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(op_a < op_b);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_b;
        endcase
    end

    // bubbles never carry a write into later stages
    assign valid_o = valid_i;
    always_comb begin
        mem_o.reg_write = valid_i && ex_i.ctrl.reg_write;
        mem_o.rd        = ex_i.rd;
        mem_o.result    = alu_result;
    end

endmodule

//--- source/forward_unit.sv
module forward_unit (
    input  logic                   mem_we_i,
    input  logic                   wb_we_i,
    input  rv_pipe_pkg::reg_addr_t ex_rs1_i,
    input  rv_pipe_pkg::reg_addr_t ex_rs2_i,
    input  rv_pipe_pkg::reg_addr_t mem_rd_i,
    input  rv_pipe_pkg::reg_addr_t wb_rd_i,
    output rv_pipe_pkg::fwd_sel_t  fwd_a_o,
    output rv_pipe_pkg::fwd_sel_t  fwd_b_o
);
    import rv_pipe_pkg::*;

    // newest producer first, EX/MEM before MEM/WB
    // x0 never carries a write enable, so no zero check here
    function automatic fwd_sel_t pick_src(input reg_addr_t src);
        if (mem_we_i && (mem_rd_i == src)) begin
            pick_src = FWD_MEM;
        end else if (wb_we_i && (wb_rd_i == src)) begin
            pick_src = FWD_WB;
        end else begin
            pick_src = FWD_RF;
        end
    endfunction

    // a producer three ahead is already in the regfile via write-through
    always_comb begin
        fwd_a_o = pick_src(ex_rs1_i);
        fwd_b_o = pick_src(ex_rs2_i);
    end

endmodule

//--- source/reg_file.sv
`include "rv_settings.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_pipe_pkg::reg_addr_t rs1_i,
    input  rv_pipe_pkg::reg_addr_t rs2_i,
    input  logic                  we_i,
    input  rv_pipe_pkg::reg_addr_t wr_addr_i,
    input  rv_pipe_pkg::word_t     wr_data_i,
    output rv_pipe_pkg::word_t     rs1_data_o,
    output rv_pipe_pkg::word_t     rs2_data_o
);
    import rv_pipe_pkg::*;

    word_t regs [`NUM_REGS];

    // x0 never written, reset leaves it at zero
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through, decode sees the writeback of the same cycle
    always_comb begin
        rs1_data_o = regs[rs1_i];
        rs2_data_o = regs[rs2_i];
        if (we_i && (wr_addr_i != '0) && (wr_addr_i == rs1_i)) begin
            rs1_data_o = wr_data_i;
        end
        if (we_i && (wr_addr_i != '0) && (wr_addr_i == rs2_i)) begin
            rs2_data_o = wr_data_i;
        end
    end

endmodule

//--- source/rv_core.sv
module rv_core (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  rv_pipe_pkg::word_t     instr_i,
    output logic                   wb_valid_o,
    output rv_pipe_pkg::reg_addr_t wb_rd_o,
    output rv_pipe_pkg::word_t     wb_data_o
);
    import rv_pipe_pkg::*;

    logic    if_id_valid;
    word_t   if_id_instr;
    logic    id_valid;
    id_ex_t  id_ex_d;
    logic    id_ex_valid;
    id_ex_t  id_ex_q;
    logic    ex_valid;
    ex_mem_t ex_mem_d;
    logic    ex_mem_valid;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    logic    mem_wb_valid;
    mem_wb_t mem_wb_q;
    logic    mem_we;

    // IF/ID, instruction strobe captured every edge
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            if_id_valid <= 1'b0;
        end else begin
            if_id_valid <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if_id_instr <= instr_i;
    end

    decode_stage decode_stage_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .valid_i   (if_id_valid),
        .instr_i   (if_id_instr),
        .wb_we_i   (wb_valid_o),
        .wb_rd_i   (wb_rd_o),
        .wb_data_i (wb_data_o),
        .valid_o   (id_valid),
        .ex_o      (id_ex_d)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (id_valid),
        .data_i  (id_ex_d),
        .valid_o (id_ex_valid),
        .data_o  (id_ex_q)
    );

    // write enables qualified by stage valid
    assign mem_we = ex_mem_valid && ex_mem_q.reg_write;

    execute_stage execute_stage_inst (
        .valid_i      (id_ex_valid),
        .ex_i         (id_ex_q),
        .mem_result_i (ex_mem_q.result),
        .wb_result_i  (mem_wb_q.result),
        .mem_rd_i     (ex_mem_q.rd),
        .wb_rd_i      (mem_wb_q.rd),
        .mem_we_i     (mem_we),
        .wb_we_i      (wb_valid_o),
        .valid_o      (ex_valid),
        .mem_o        (ex_mem_d)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (ex_valid),
        .data_i  (ex_mem_d),
        .valid_o (ex_mem_valid),
        .data_o  (ex_mem_q)
    );

    // memory stage, no loads or stores so fields pass straight on
    always_comb begin
        mem_wb_d.reg_write = ex_mem_q.reg_write;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.result    = ex_mem_q.result;
    end

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (ex_mem_valid),
        .data_i  (mem_wb_d),
        .valid_o (mem_wb_valid),
        .data_o  (mem_wb_q)
    );

    // writeback ports, also the regfile write
    assign wb_valid_o = mem_wb_valid && mem_wb_q.reg_write;
    assign wb_rd_o    = mem_wb_q.rd;
    assign wb_data_o  = mem_wb_q.result;

endmodule

//--- source/rv_pipe_pkg.sv
`include "rv_settings.svh"

package rv_pipe_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // alu operations, pass_b carries the LUI immediate
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_RF, FWD_MEM, FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        // operand b taken from the immediate
        logic    use_imm;
        logic    reg_write;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;
    } ex_mem_t;

    // same fields for now, kept apart for a real memory stage later
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;
    } mem_wb_t;

endpackage

//--- source/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath word and register file geometry
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// major opcodes kept in this core
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// funct3 codes shared by OP and OP-IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7, base form and the SUB / SRA form
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif

//--- source/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // no stall or flush, loads on every edge
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload, cleared along with the valid bit
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            data_o <= '0;
        end else begin
            data_o <= data_i;
        end
    end

endmodule

//--- testbench/rv_stim.txt
# instr    rd  value      (hex; rd 00 means no writeback expected)
# operand setup first so every pass starts from the same registers
00500093 01 00000005
FFD00113 02 FFFFFFFD
800001B7 03 80000000
00208233 04 00000002
402082B3 05 00000008
00409333 06 00000014
001123B3 07 00000001
00113433 08 00000000
001144B3 09 FFFFFFF8
0041D533 0A 20000000
4041D5B3 0B E0000000
0020E633 0C FFFFFFFD
0020F6B3 0D 00000005
FFE12713 0E 00000001
FFF0C813 10 FFFFFFFA
0F017913 12 000000F0
00409993 13 00000050
4041DA93 15 F8000000
00708013 00 00000000
00100B33 16 00000005
00A000FF 00 00000000
022080B3 00 00000000
00008BB3 17 00000005
06400C13 18 00000064
001C0C93 19 00000065
002C0D13 1A 00000066
019C0DB3 1B 000000C9
41AD8E33 1C 00000063
12345EB7 1D 12345000
40115F33 1E FFFFFFFF
00209FB3 1F A0000000

//--- testbench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    // free running, starts low so the first rising edge is at PERIOD/2
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk_o = ~clk_o;
    end

endmodule

//--- testbench/tb_rv_core.sv
module tb_rv_core;
    import rv_pipe_pkg::*;

    localparam int RESET_CYCLES = 10;
    // quiet cycles after reset and after draining the pipe
    localparam int IDLE_CYCLES  = 4;

    logic      clk;
    logic      rst_n_i;
    logic      instr_valid_i;
    word_t     instr_i;
    logic      wb_valid_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;

    // stimulus lines as read from the data file
    word_t     stim_instr [$];
    reg_addr_t stim_rd [$];
    word_t     stim_value [$];

    // writebacks still owed by the DUT, oldest first
    reg_addr_t exp_rd_q [$];
    word_t     exp_data_q [$];

    integer seed = 32'hc3ccf356;
    int     cycles = 0;
    int     limit = 1000;

    tb_clock #(.PERIOD(8)) tb_clock_inst (
        .clk_o (clk)
    );

    rv_core rv_core_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // columns are instruction, expected rd, expected value, all hex
    task automatic read_stim();
        int    fd;
        int    fields;
        string line;
        word_t word;
        word_t rd;
        word_t value;
        fd = $fopen("testbench/rv_stim.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file testbench/rv_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    // comment and blank lines give fewer than three fields
                    fields = $sscanf(line, "%h %h %h", word, rd, value);
                    if (fields == 3) begin
                        stim_instr.push_back(word);
                        stim_rd.push_back(reg_addr_t'(rd));
                        stim_value.push_back(value);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n_i       <= 1'b0;
        instr_valid_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
    endtask

    // one full pass over the stimulus, gaps of 0..3 idle cycles if asked
    task automatic run_pass(input bit random_gaps);
        int gap;
        apply_reset();
        // nothing may come out of an empty pipe
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("wb_valid_o", 32'(wb_valid_o), 32'd0);
        end
        for (int i = 0; i < stim_instr.size(); i++) begin
            @(posedge clk);
            instr_valid_i <= 1'b1;
            instr_i       <= stim_instr[i];
            // rd zero marks a line with no writeback
            if (stim_rd[i] != '0) begin
                exp_rd_q.push_back(stim_rd[i]);
                exp_data_q.push_back(stim_value[i]);
            end
            gap = random_gaps ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                @(posedge clk);
                instr_valid_i <= 1'b0;
                // junk on the bus while valid is low
                instr_i       <= $random(seed);
            end
        end
        @(posedge clk);
        instr_valid_i <= 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        // catch any extra writeback behind the last one
        repeat (IDLE_CYCLES) @(negedge clk);
    endtask

    // writeback monitor, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n_i && (wb_valid_o === 1'b1)) begin
            if (exp_rd_q.size() == 0) begin
                fail_run($sformatf("unexpected writeback to x%0d at %0t", wb_rd_o, $time));
            end else begin
                check_value("wb_rd_o", 32'(wb_rd_o), 32'(exp_rd_q[0]));
                check_value("wb_data_o", wb_data_o, exp_data_q[0]);
                exp_rd_q.delete(0);
                exp_data_q.delete(0);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            fail_run($sformatf("timeout after %0d cycles, %0d writebacks never arrived",
                               cycles, exp_rd_q.size()));
        end
    end

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        read_stim();
        if (stim_instr.size() == 0) begin
            fail_run("the stimulus file holds no instructions");
        end else begin
            // two passes, each up to 4 cycles per line plus reset, idle and drain
            limit = 2 * (RESET_CYCLES + 2 * IDLE_CYCLES + stim_instr.size() * 4 + 4 + 2)
                    + 20;
            run_pass(1'b0);
            run_pass(1'b1);
            $display("All checks passed");
            $finish;
        end
    end

endmodule
